//--- src.f
+incdir+common
common/blackjack_pkg.sv
deck/card_dealer.sv
game/hand_tracker.sv
game/game_fsm.sv
display/hand_display.sv
rtl/blackjack_top.sv
tb/tb_blackjack.sv

//--- Makefile
# Verilator build and run of the blackjack table testbench
TOP       ?= tb_blackjack
VERILATOR ?= verilator
SEED_LOG  ?= sim.log
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -sv --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(SEED_LOG)
	grep -q "^=== PASS ===$$" $(SEED_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)

//--- tb/tb_blackjack.sv
// Plays forty seeded random games, hit presses outside the player turn only after hit or stand
`timescale 1ns/1ps
`include "blackjack_consts.svh"

module tb_blackjack;
    import blackjack_pkg::*;

    localparam int NUM_GAMES   = 40;
    localparam int CYCLE_LIMIT = NUM_GAMES * 200;

    logic clk;
    logic rst;
    logic start;
    logic hit;
    logic stand;
    logic [`BJ_SEED_W-1:0] seed;
    logic hand_select;
    outcome_t outcome;
    logic game_done;
    logic player_turn;
    seg_t [`BJ_HAND_MAX:0] hand_digits;

    // Reference model, index 0 is the player and 1 the house
    logic [`BJ_LFSR_W-1:0] m_lfsr;
    rank_t m_cards [2][`BJ_HAND_MAX];
    int m_count [2];
    int m_points [2];

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int game_errors = 0;

    blackjack_top DUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .hit         (hit),
        .stand       (stand),
        .seed        (seed),
        .hand_select (hand_select),
        .outcome     (outcome),
        .game_done   (game_done),
        .player_turn (player_turn),
        .hand_digits (hand_digits)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit, a game needs well under 200 cycles
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Shift left, new bit 0 is the parity of bits 15, 13, 12, 10
    function automatic rank_t draw_card();
        m_lfsr = {m_lfsr[`BJ_LFSR_W-2:0], ^(m_lfsr & `BJ_LFSR_TAPS)};
        return rank_t'(int'(m_lfsr[3:0]) % 13 + 1);
    endfunction

    function automatic void deal_to(input int h);
        rank_t r;
        r = draw_card();
        m_cards[h][m_count[h]] = r;
        m_count[h] = m_count[h] + 1;
        // Face cards score ten, ace scores one
        m_points[h] = m_points[h] + ((int'(r) > 10) ? 10 : int'(r));
    endfunction

    function automatic seg_t seg_of(input rank_t r);
        case (r)
            4'd0:    return `BJ_SEG_BLANK;
            4'd1:    return `BJ_SEG_ACE;
            4'd2:    return `BJ_SEG_2;
            4'd3:    return `BJ_SEG_3;
            4'd4:    return `BJ_SEG_4;
            4'd5:    return `BJ_SEG_5;
            4'd6:    return `BJ_SEG_6;
            4'd7:    return `BJ_SEG_7;
            4'd8:    return `BJ_SEG_8;
            4'd9:    return `BJ_SEG_9;
            default: return `BJ_SEG_TEN;
        endcase
    endfunction

    function automatic outcome_t expected_outcome();
        outcome_t result;
        if (m_points[0] > `BJ_BUST_LIMIT) begin
            result = OUT_HOUSE;
        end else if (m_points[1] > `BJ_BUST_LIMIT) begin
            result = OUT_PLAYER;
        end else if (m_points[0] > m_points[1]) begin
            result = OUT_PLAYER;
        end else if (m_points[1] > m_points[0]) begin
            result = OUT_HOUSE;
        end else begin
            result = OUT_DRAW;
        end
        return result;
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        checks = checks + 1;
        if (expected != actual) begin
            errors = errors + 1;
            game_errors = game_errors + 1;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // All driving and sampling happens 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Button held two cycles, 0 is start, 1 hit, 2 stand
    task automatic press(input int which);
        case (which)
            0: start = 1'b1;
            1: hit = 1'b1;
            default: stand = 1'b1;
        endcase
        step();
        step();
        start = 1'b0;
        hit   = 1'b0;
        stand = 1'b0;
    endtask

    // Empty model slots hold zero, so they expect a blank digit
    task automatic compare_hand(input string name, input int h);
        hand_select = (h == 1);
        step();
        for (int i = 0; i < `BJ_HAND_MAX; i++) begin
            check(name, int'(seg_of(m_cards[h][i])), int'(hand_digits[i]));
        end
        check({name, "_tag"}, (h == 1) ? int'(`BJ_SEG_H) : int'(`BJ_SEG_P),
              int'(hand_digits[`BJ_HAND_MAX]));
        hand_select = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        int threshold;
        bit turn_over;
        bit bust;
        rnd = $urandom(32'h4708);
        rst = 1'b0;
        start = 1'b0;
        hit = 1'b0;
        stand = 1'b0;
        hand_select = 1'b0;
        rnd = $urandom;
        seed = rnd[`BJ_SEED_W-1:0];
        m_lfsr = {{(`BJ_LFSR_W-`BJ_SEED_W){1'b1}}, seed};
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        step();
        for (int g = 0; g < NUM_GAMES; g++) begin
            game_errors = 0;
            // New game clears both hands and deals P, H, P, H
            press(0);
            for (int h = 0; h < 2; h++) begin
                m_count[h] = 0;
                m_points[h] = 0;
                for (int i = 0; i < `BJ_HAND_MAX; i++) begin
                    m_cards[h][i] = '0;
                end
            end
            for (int k = 0; k < 4; k++) begin
                deal_to(k % 2);
            end
            while (!player_turn) step();
            // Result of the last game is gone once a new one starts
            check("deal_outcome", int'(OUT_NONE), int'(outcome));
            compare_hand("deal_player", 0);
            compare_hand("deal_house", 1);
            turn_over = 1'b0;
            bust = 1'b0;
            while (!turn_over) begin
                // Hit often on low totals, rarely on high ones
                threshold = (m_points[0] < 12) ? 90 : ((m_points[0] < 17) ? 50 : 15);
                rnd = $urandom % 100;
                if (int'(rnd) < threshold) begin
                    press(1);
                    deal_to(0);
                    while (player_turn) step();
                    while (!player_turn && !game_done) step();
                    compare_hand("hit", 0);
                    bust = (m_points[0] > `BJ_BUST_LIMIT);
                    turn_over = bust || (m_points[0] == `BJ_BUST_LIMIT)
                             || (m_count[0] == `BJ_HAND_MAX);
                end else begin
                    press(2);
                    while (player_turn) step();
                    turn_over = 1'b1;
                end
            end
            // House draws under 17 until five cards, not at all after a bust
            while (!bust && m_points[1] < `BJ_HOUSE_STAND && m_count[1] < `BJ_HAND_MAX) begin
                deal_to(1);
            end
            // stray hit during the house turn or the done state
            rnd = $urandom % 2;
            if (rnd == 1) begin
                press(1);
            end
            while (!game_done) step();
            check("outcome", int'(expected_outcome()), int'(outcome));
            compare_hand("player_final", 0);
            compare_hand(bust ? "bust_house" : "house_rule", 1);
            // Hit with the game over leaves everything as it was
            press(1);
            repeat (4) step();
            check("stray_hit_done", 1, int'(game_done));
            check("stray_hit_turn", 0, int'(player_turn));
            check("stray_hit_outcome", int'(expected_outcome()), int'(outcome));
            compare_hand("stray_hit_player", 0);
            $display("game %0d: player %0d, house %0d, outcome %0d, errors %0d",
                     g, m_points[0], m_points[1], int'(outcome), game_errors);
        end
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- rtl/blackjack_top.sv
// Buttons are active high and may be asynchronous, the seed is sampled only while rst is low
`timescale 1ns/1ps
`include "blackjack_consts.svh"

module blackjack_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic                                hit,
    input  logic                                stand,
    input  logic [`BJ_SEED_W-1:0]               seed,
    input  logic                                hand_select,
    output blackjack_pkg::outcome_t             outcome,
    output logic                                game_done,
    output logic                                player_turn,
    output blackjack_pkg::seg_t [`BJ_HAND_MAX:0] hand_digits
);
    import blackjack_pkg::*;

    // Card handshake
    logic card_req;
    logic card_valid;
    rank_t card_rank;

    // Sequencer to hand store
    logic to_house;
    logic clear_hands;

    // Hand state
    rank_t [`BJ_HAND_MAX-1:0] player_cards;
    rank_t [`BJ_HAND_MAX-1:0] house_cards;
    card_idx_t player_count;
    card_idx_t house_count;
    points_t player_points;
    points_t house_points;

    card_dealer u_dealer (
        .clk        (clk),
        .rst        (rst),
        .seed       (seed),
        .card_req   (card_req),
        .card_valid (card_valid),
        .card_rank  (card_rank)
    );

    hand_tracker u_hands (
        .clk           (clk),
        .rst           (rst),
        .clear_hands   (clear_hands),
        .card_valid    (card_valid),
        .card_rank     (card_rank),
        .to_house      (to_house),
        .player_cards  (player_cards),
        .house_cards   (house_cards),
        .player_count  (player_count),
        .house_count   (house_count),
        .player_points (player_points),
        .house_points  (house_points)
    );

    game_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .hit           (hit),
        .stand         (stand),
        .card_req      (card_req),
        .to_house      (to_house),
        .clear_hands   (clear_hands),
        .player_points (player_points),
        .house_points  (house_points),
        .player_count  (player_count),
        .house_count   (house_count),
        .player_turn   (player_turn),
        .game_done     (game_done),
        .outcome       (outcome)
    );

    hand_display u_display (
        .hand_select  (hand_select),
        .player_cards (player_cards),
        .house_cards  (house_cards),
        .hand_digits  (hand_digits)
    );

endmodule

//--- display/hand_display.sv
// Purely combinational, so digits follow the hand registers and the select switch directly
`timescale 1ns/1ps
`include "blackjack_consts.svh"

module hand_display (
    input  logic                                     hand_select,
    input  blackjack_pkg::rank_t [`BJ_HAND_MAX-1:0]  player_cards,
    input  blackjack_pkg::rank_t [`BJ_HAND_MAX-1:0]  house_cards,
    output blackjack_pkg::seg_t  [`BJ_HAND_MAX:0]    hand_digits
);
    import blackjack_pkg::*;

    rank_t [`BJ_HAND_MAX-1:0] shown;

    // Rank to glyph, ten through king all show as 10
    function automatic seg_t rank_to_seg(input rank_t rank);
        case (rank)
            4'd1:  return `BJ_SEG_ACE;
            4'd2:  return `BJ_SEG_2;
            4'd3:  return `BJ_SEG_3;
            4'd4:  return `BJ_SEG_4;
            4'd5:  return `BJ_SEG_5;
            4'd6:  return `BJ_SEG_6;
            4'd7:  return `BJ_SEG_7;
            4'd8:  return `BJ_SEG_8;
            4'd9:  return `BJ_SEG_9;
            4'd10, 4'd11, 4'd12, 4'd13: return `BJ_SEG_TEN;
            default: return `BJ_SEG_BLANK;
        endcase
    endfunction

    // Low selects the player
    assign shown = hand_select ? house_cards : player_cards;

    always_comb begin
        // Digit 0 is the first card dealt
        for (int i = 0; i < `BJ_HAND_MAX; i++) begin
            hand_digits[i] = rank_to_seg(shown[i]);
        end
        // Top digit names the hand
        hand_digits[`BJ_HAND_MAX] = hand_select ? `BJ_SEG_H : `BJ_SEG_P;
    end

endmodule

//--- game/game_fsm.sv
// Each draw takes three cycles, and hit or stand count only as rising edges during player_turn
`timescale 1ns/1ps
`include "blackjack_consts.svh"

module game_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       hit,
    input  logic                       stand,
    output logic                       card_req,
    output logic                       to_house,
    output logic                       clear_hands,
    input  blackjack_pkg::points_t     player_points,
    input  blackjack_pkg::points_t     house_points,
    input  blackjack_pkg::card_idx_t   player_count,
    input  blackjack_pkg::card_idx_t   house_count,
    output logic                       player_turn,
    output logic                       game_done,
    output blackjack_pkg::outcome_t    outcome
);
    import blackjack_pkg::*;

    // Draw path is REQ, WAIT while the card is valid, then CHECK on the new totals
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_REQ,
        ST_WAIT,
        ST_CHECK,
        ST_PLAYER,
        ST_DONE
    } table_state_t;

    table_state_t state;
    // Button vectors ordered start, hit, stand
    logic [2:0] btn_meta;
    logic [2:0] btn_sync;
    logic [2:0] btn_prev;
    logic [2:0] btn_rise;
    logic dealing;
    logic [1:0] deal_cnt;
    logic player_bust;
    logic player_stands;
    logic house_draws;
    outcome_t final_result;

    assign btn_rise = btn_sync & ~btn_prev;

    assign card_req    = (state == ST_REQ);
    assign clear_hands = (state == ST_CLEAR);
    assign player_turn = (state == ST_PLAYER);
    assign game_done   = (state == ST_DONE);

    // Player checks after each hit
    assign player_bust   = (player_points > points_t'(`BJ_BUST_LIMIT));
    assign player_stands = (player_points == points_t'(`BJ_BUST_LIMIT))
                        || (player_count == card_idx_t'(`BJ_HAND_MAX));
    // House keeps drawing under 17 until the hand is full
    assign house_draws   = (house_points < points_t'(`BJ_HOUSE_STAND))
                        && (house_count < card_idx_t'(`BJ_HAND_MAX));

    // Winner once the house is done
    always_comb begin
        if (house_points > points_t'(`BJ_BUST_LIMIT)) begin
            final_result = OUT_PLAYER;
        end else if (player_points > house_points) begin
            final_result = OUT_PLAYER;
        end else if (house_points > player_points) begin
            final_result = OUT_HOUSE;
        end else begin
            final_result = OUT_DRAW;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            state    <= ST_IDLE;
            dealing  <= 1'b0;
            deal_cnt <= '0;
            to_house <= 1'b0;
            outcome  <= OUT_NONE;
        end else begin
            // Two-flop synchronizer, third stage for edge detect
            btn_meta <= {start, hit, stand};
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (btn_rise[2]) begin
                        outcome <= OUT_NONE;
                        state   <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    dealing  <= 1'b1;
                    deal_cnt <= '0;
                    to_house <= 1'b0;
                    state    <= ST_REQ;
                end
                ST_REQ: state <= ST_WAIT;
                ST_WAIT: state <= ST_CHECK;
                ST_CHECK: begin
                    if (dealing) begin
                        // Deal alternates P, H, P, H
                        if (deal_cnt == 2'd3) begin
                            dealing  <= 1'b0;
                            to_house <= 1'b0;
                            state    <= ST_PLAYER;
                        end else begin
                            deal_cnt <= deal_cnt + 1'b1;
                            to_house <= ~to_house;
                            state    <= ST_REQ;
                        end
                    end else if (!to_house) begin
                        if (player_bust) begin
                            // House wins without drawing
                            outcome <= OUT_HOUSE;
                            state   <= ST_DONE;
                        end else if (player_stands) begin
                            // Stay in CHECK, house decides next cycle
                            to_house <= 1'b1;
                        end else begin
                            state <= ST_PLAYER;
                        end
                    end else if (house_draws) begin
                        state <= ST_REQ;
                    end else begin
                        outcome <= final_result;
                        state   <= ST_DONE;
                    end
                end
                ST_PLAYER: begin
                    // Hit wins over a simultaneous stand
                    if (btn_rise[1]) begin
                        state <= ST_REQ;
                    end else if (btn_rise[0]) begin
                        to_house <= 1'b1;
                        state    <= ST_CHECK;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_outcome_hold: assert property (@(posedge clk) disable iff (!rst)
        game_done ##1 game_done |-> $stable(outcome))
        else $error("outcome changed while game_done was high");

endmodule

//--- game/hand_tracker.sv
// A card offered to a full hand is dropped, and face cards score 10 with ace always 1
`timescale 1ns/1ps
`include "blackjack_consts.svh"

module hand_tracker (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      clear_hands,
    input  logic                                      card_valid,
    input  blackjack_pkg::rank_t                      card_rank,
    input  logic                                      to_house,
    output blackjack_pkg::rank_t [`BJ_HAND_MAX-1:0]   player_cards,
    output blackjack_pkg::rank_t [`BJ_HAND_MAX-1:0]   house_cards,
    output blackjack_pkg::card_idx_t                  player_count,
    output blackjack_pkg::card_idx_t                  house_count,
    output blackjack_pkg::points_t                    player_points,
    output blackjack_pkg::points_t                    house_points
);
    import blackjack_pkg::*;

    // Entry 0 is the player, entry 1 the house
    rank_t [`BJ_HAND_MAX-1:0] cards [2];
    card_idx_t count [2];
    points_t points [2];
    points_t card_value;
    logic hand_full;

    // J, Q and K all score as ten
    assign card_value = (card_rank > rank_t'(10)) ? points_t'(10) : points_t'(card_rank);
    assign hand_full  = (count[to_house] >= card_idx_t'(`BJ_HAND_MAX));

    // Empty slots hold zero so the display blanks them
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int h = 0; h < 2; h++) begin
                cards[h]  <= '0;
                count[h]  <= '0;
                points[h] <= '0;
            end
        end else if (clear_hands) begin
            for (int h = 0; h < 2; h++) begin
                cards[h]  <= '0;
                count[h]  <= '0;
                points[h] <= '0;
            end
        end else if (card_valid && !hand_full) begin
            cards[to_house][count[to_house]] <= card_rank;
            count[to_house]  <= count[to_house] + 1'b1;
            points[to_house] <= points[to_house] + card_value;
        end
    end

    assign player_cards  = cards[0];
    assign house_cards   = cards[1];
    assign player_count  = count[0];
    assign house_count   = count[1];
    assign player_points = points[0];
    assign house_points  = points[1];

    a_count_limit: assert property (@(posedge clk) disable iff (!rst)
        (count[0] <= card_idx_t'(`BJ_HAND_MAX)) && (count[1] <= card_idx_t'(`BJ_HAND_MAX)))
        else $error("hand count above the five-card limit");

endmodule

//--- deck/card_dealer.sv
// Cards are drawn with replacement from an LFSR, so a rank can repeat more than four times
`timescale 1ns/1ps
`include "blackjack_consts.svh"

module card_dealer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BJ_SEED_W-1:0]  seed,
    input  logic                   card_req,
    output logic                   card_valid,
    output blackjack_pkg::rank_t   card_rank
);
    import blackjack_pkg::*;

    localparam rank_t RANK_COUNT = rank_t'(13);

    logic [`BJ_LFSR_W-1:0] lfsr;
    logic [`BJ_LFSR_W-1:0] lfsr_next;
    logic seeded;
    rank_t low_bits;
    rank_t rank_index;

    // Shift left, new bit 0 is the parity of the tapped bits
    assign lfsr_next = {lfsr[`BJ_LFSR_W-2:0], ^(lfsr & `BJ_LFSR_TAPS)};

    // Low nibble folded into 0..12, then shifted to ace..king
    assign low_bits   = lfsr[`BJ_RANK_W-1:0];
    assign rank_index = (low_bits >= RANK_COUNT) ? low_bits - RANK_COUNT : low_bits;
    assign card_rank  = rank_index + rank_t'(1);

    // Handshake and seed flag
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            card_valid <= 1'b0;
            seeded     <= 1'b0;
        end else begin
            card_valid <= card_req;
            seeded     <= 1'b1;
        end
    end

    // Seed reloads on every clock while seeded is low, so through all of reset
    // Upper bits forced to ones keep the register away from the all-zero lockup
    always_ff @(posedge clk) begin
        if (!seeded) begin
            lfsr <= {{(`BJ_LFSR_W-`BJ_SEED_W){1'b1}}, seed};
        end else if (card_req) begin
            lfsr <= lfsr_next;
        end
    end

    // Sequencer waits out each card before asking again
    a_valid_single: assert property (@(posedge clk) disable iff (!rst)
        card_valid |=> !card_valid)
        else $error("card_valid high in back-to-back cycles");

endmodule

//--- common/blackjack_pkg.sv
// Shared types only, and the constants header must be on the include path before this is compiled
`include "blackjack_consts.svh"

package blackjack_pkg;

    // Card rank
    // Zero marks an empty slot, 1 to 13 run from ace to king
    typedef logic [`BJ_RANK_W-1:0] rank_t;

    // Running hand total, five tens fit with room to spare
    typedef logic [`BJ_SUM_W-1:0] points_t;

    // Number of cards held in one hand
    typedef logic [`BJ_IDX_W-1:0] card_idx_t;

    // One seven-segment digit, active low
    typedef logic [6:0] seg_t;

    // Game result
    // OUT_NONE while a game is running or before the first one
    typedef enum logic [1:0] {
        OUT_NONE   = 2'b00,
        OUT_PLAYER = 2'b01,
        OUT_HOUSE  = 2'b10,
        OUT_DRAW   = 2'b11
    } outcome_t;

endpackage

//--- common/blackjack_consts.svh
// Segment codes are active low with bit 0 on segment a, and ranks ten to king share the "10" glyph
`ifndef BLACKJACK_CONSTS_SVH
`define BLACKJACK_CONSTS_SVH

// Card and hand sizes
`define BJ_RANK_W       4
`define BJ_SUM_W        6
`define BJ_HAND_MAX     5
`define BJ_IDX_W        3

// Table rules
`define BJ_BUST_LIMIT   21
`define BJ_HOUSE_STAND  17

// Card source, feedback from bits 15, 13, 12 and 10
`define BJ_SEED_W       6
`define BJ_LFSR_W       16
`define BJ_LFSR_TAPS    16'hB400

// Seven-segment glyphs, bit 6 is segment g
`define BJ_SEG_BLANK    7'b1111111
`define BJ_SEG_ACE      7'b0001000
`define BJ_SEG_2        7'b0100100
`define BJ_SEG_3        7'b0110000
`define BJ_SEG_4        7'b0011001
`define BJ_SEG_5        7'b0010010
`define BJ_SEG_6        7'b0000010
`define BJ_SEG_7        7'b1111000
`define BJ_SEG_8        7'b0000000
`define BJ_SEG_9        7'b0011000
`define BJ_SEG_TEN      7'b1000000
`define BJ_SEG_P        7'b0001100
`define BJ_SEG_H        7'b0001001
`endif
